//--- df_macros.svh
/*
 * sizes and bus address map of the deblocking buffer bank
 * addresses below 6*DF_LANES read buffer rows, four rows per buffer
 * the edge schedule in the decoder assumes DF_EDGES is 48
 */
`ifndef DF_MACROS_SVH
`define DF_MACROS_SVH

// ------------------------------------------------------------------------
// schedule sizes
// ------------------------------------------------------------------------
`define DF_LANES      4   // line steps per edge
`define DF_EDGES      48  // edges per macroblock

// ------------------------------------------------------------------------
// wishbone address map
// ------------------------------------------------------------------------
`define DF_ADR_P      24  // p word, stored only
`define DF_ADR_Q      25  // q word, commits the step
`define DF_ADR_STATUS 26  // {edge, lane} read back

`define DF_WORD_W     32  // bus and buffer word

`endif

//--- df_pkg.sv
/*
 * types shared by the deblocking buffer bank
 * a pixel word packs sample 3 in the top byte, sample 0 in the bottom
 * buf_id_t values 0..5 match the read address map (address / 4)
 */
`include "df_macros.svh"

package df_pkg;

	typedef logic [7:0]                      pixel_t;
	typedef logic [`DF_WORD_W-1:0]           pix_word_t;  // {s3, s2, s1, s0}
	typedef logic [$clog2(`DF_LANES)-1:0]    lane_t;      // step, byte lane and row
	typedef logic [$clog2(`DF_EDGES)-1:0]    edge_t;      // edge index 0..47
	typedef logic [4:0]                      wb_adr_t;

	// how a buffer takes a committed step
	typedef enum logic [1:0] {
		MODE_HOLD  = 2'd0,
		MODE_ROW_Q = 2'd1,  // whole row of q, untransposed
		MODE_COL_P = 2'd2,  // byte lane of p, transposed
		MODE_COL_Q = 2'd3   // byte lane of q, transposed
	} buf_mode_t;

	typedef enum logic [2:0] {
		BUF0 = 3'd0,
		BUF1 = 3'd1,
		BUF2 = 3'd2,
		BUF3 = 3'd3,
		T0   = 3'd4,
		T1   = 3'd5
	} buf_id_t;

	typedef enum logic {
		BUS_IDLE = 1'b0,
		BUS_ACK  = 1'b1
	} bus_state_t;

	// one mode per buffer, indexed by buf_id_t
	typedef buf_mode_t [T1:BUF0] mode_vec_t;

endpackage

//--- df_step_if.sv
/*
 * one committed line step, from the bus slave to counter, decoder and buffers
 * commit is a single-cycle pulse; lane and edge_idx come from the counter
 */
`timescale 1ns/10ps

interface df_step_if;

	logic              commit;    // step taken at the end of this cycle
	df_pkg::pix_word_t p_word;    // {p3, p2, p1, p0}
	df_pkg::pix_word_t q_word;    // {q3, q2, q1, q0}
	df_pkg::lane_t     lane;
	df_pkg::edge_t     edge_idx;

	modport bus     (output commit, p_word, q_word, input lane, edge_idx);
	modport counter (input commit, output lane, edge_idx);
	modport decoder (input edge_idx);
	modport buffers (input commit, p_word, q_word, lane);

endinterface

//--- df_bus_fsm.sv
/*
 * wishbone classic slave, one fixed wait: ack one cycle after cyc & stb
 * ack then drops for a cycle, so each access takes two cycles
 * the master must hold adr, we and dat_i until ack
 */
`timescale 1ns/10ps
`include "df_macros.svh"

module df_bus_fsm (
	input  logic               gclk_DF,
	input  logic               reset_n,
	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  df_pkg::wb_adr_t    wb_adr,
	input  df_pkg::pix_word_t  wb_dat_i,
	output df_pkg::pix_word_t  wb_dat_o,
	output logic               wb_ack,
	input  df_pkg::pix_word_t  rd_word,
	output df_pkg::buf_id_t    rd_buf,
	output df_pkg::lane_t      rd_row,
	df_step_if.bus             step
);

	df_pkg::bus_state_t state, state_nxt;
	df_pkg::pix_word_t  p_latch;
	df_pkg::pix_word_t  rd_mux;
	df_pkg::pix_word_t  status_word;
	logic               req;
	logic               wr_cycle;
	logic               in_buf_range;

	assign req      = wb_cyc && wb_stb;
	assign wb_ack   = (state == df_pkg::BUS_ACK);
	assign wr_cycle = wb_ack && req && wb_we;  // write lands at the edge ending ack

	// ------------------------------------------------------------------------
	// handshake
	// ------------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			df_pkg::BUS_IDLE: if (req) state_nxt = df_pkg::BUS_ACK;
			df_pkg::BUS_ACK:  state_nxt = df_pkg::BUS_IDLE;  // at least one idle cycle
			default:          state_nxt = df_pkg::BUS_IDLE;
		endcase
	end

	always_ff @(posedge gclk_DF or negedge reset_n) begin
		if (!reset_n)
			state <= df_pkg::BUS_IDLE;
		else
			state <= state_nxt;
	end

	// ------------------------------------------------------------------------
	// read path, decoded in the request cycle and registered for ack
	// ------------------------------------------------------------------------
	assign rd_buf       = df_pkg::buf_id_t'(wb_adr[4:2]);
	assign rd_row       = df_pkg::lane_t'(wb_adr[1:0]);
	assign in_buf_range = (wb_adr < df_pkg::wb_adr_t'((df_pkg::T1 + 1) * `DF_LANES));
	assign status_word  = df_pkg::pix_word_t'({step.edge_idx, step.lane});

	always_comb begin
		if (in_buf_range)
			rd_mux = rd_word;
		else if (wb_adr == df_pkg::wb_adr_t'(`DF_ADR_STATUS))
			rd_mux = status_word;
		else
			rd_mux = '0;  // unmapped
	end

	always_ff @(posedge gclk_DF or negedge reset_n) begin
		if (!reset_n)
			wb_dat_o <= '0;
		else if (state == df_pkg::BUS_IDLE && req)
			wb_dat_o <= wb_we ? '0 : rd_mux;
	end

	// ------------------------------------------------------------------------
	// step words
	// ------------------------------------------------------------------------
	always_ff @(posedge gclk_DF or negedge reset_n) begin
		if (!reset_n)
			p_latch <= '0;
		else if (wr_cycle && wb_adr == df_pkg::wb_adr_t'(`DF_ADR_P))
			p_latch <= wb_dat_i;
	end

	assign step.commit = wr_cycle && (wb_adr == df_pkg::wb_adr_t'(`DF_ADR_Q));
	assign step.p_word = p_latch;
	assign step.q_word = wb_dat_i;  // q goes straight through in the commit cycle

endmodule

//--- df_edge_counter.sv
/*
 * lane counts 0..DF_LANES-1 on each commit, the edge index steps on lane wrap
 * and returns to 0 after the last edge of the macroblock
 */
`timescale 1ns/10ps
`include "df_macros.svh"

module df_edge_counter (
	input  logic       gclk_DF,
	input  logic       reset_n,
	df_step_if.counter step
);

	logic lane_last;
	logic edge_last;

	assign lane_last = (step.lane == df_pkg::lane_t'(`DF_LANES - 1));
	assign edge_last = (step.edge_idx == df_pkg::edge_t'(`DF_EDGES - 1));

	always_ff @(posedge gclk_DF or negedge reset_n) begin
		if (!reset_n) begin
			step.lane     <= '0;
			step.edge_idx <= '0;
		end
		else if (step.commit) begin
			step.lane <= step.lane + 1'b1;  // wraps by width
			if (lane_last) begin
				if (edge_last)
					step.edge_idx <= '0;  // next macroblock
				else
					step.edge_idx <= step.edge_idx + 1'b1;
			end
		end
	end

endmodule

//--- df_schedule_decoder.sv
/*
 * edge schedule of one macroblock: write mode of each buffer per edge
 * purely combinational; edges not listed hold the buffer
 * row writes are matched before transposed writes
 */
`timescale 1ns/10ps

module df_schedule_decoder (
	df_step_if.decoder        step,
	output df_pkg::mode_vec_t modes
);

	always_comb begin
		for (int i = df_pkg::BUF0; i <= df_pkg::T1; i++)
			modes[i] = df_pkg::MODE_HOLD;

		// --------------------------------------------------------------------
		// buf0 to buf3
		// --------------------------------------------------------------------
		case (step.edge_idx)
			0, 4, 6, 12, 16, 20, 22, 28, 32, 36, 40, 44:
				modes[df_pkg::BUF0] = df_pkg::MODE_ROW_Q;
			1, 5, 10, 14, 17, 26, 30, 33, 38, 41, 46:
				modes[df_pkg::BUF0] = df_pkg::MODE_COL_P;  // p side of the edge
			default: ;
		endcase

		case (step.edge_idx)
			1, 8, 13, 17, 24, 29, 37, 45:
				modes[df_pkg::BUF1] = df_pkg::MODE_ROW_Q;
			6, 22:
				modes[df_pkg::BUF1] = df_pkg::MODE_COL_P;
			10, 26, 33, 41:
				modes[df_pkg::BUF1] = df_pkg::MODE_COL_Q;
			default: ;
		endcase

		case (step.edge_idx)
			2, 7, 18, 23, 34, 42:
				modes[df_pkg::BUF2] = df_pkg::MODE_ROW_Q;
			3, 11, 19, 27, 35, 43:
				modes[df_pkg::BUF2] = df_pkg::MODE_COL_P;
			21, 30, 38, 46:
				modes[df_pkg::BUF2] = df_pkg::MODE_COL_Q;
			default: ;
		endcase

		case (step.edge_idx)
			3, 19:
				modes[df_pkg::BUF3] = df_pkg::MODE_ROW_Q;
			7, 23:
				modes[df_pkg::BUF3] = df_pkg::MODE_COL_P;
			11, 25, 27, 35, 43:
				modes[df_pkg::BUF3] = df_pkg::MODE_COL_Q;
			default: ;
		endcase

		// --------------------------------------------------------------------
		// transpose registers, column writes only
		// --------------------------------------------------------------------
		case (step.edge_idx)
			4, 8, 12, 15, 20, 24, 28, 31, 36, 39, 44, 47:
				modes[df_pkg::T0] = df_pkg::MODE_COL_P;
			default: ;
		endcase

		case (step.edge_idx)
			9, 13, 21, 25, 29, 37, 45:
				modes[df_pkg::T1] = df_pkg::MODE_COL_P;
			31, 39, 47:
				modes[df_pkg::T1] = df_pkg::MODE_COL_Q;  // last vertical edges
			default: ;
		endcase
	end

endmodule

//--- df_pixel_buffers.sv
/*
 * buf0..buf3, t0 and t1, each four rows of one pixel word
 * a commit at lane L writes row L whole, or byte lane L of every row
 * read-back is combinational; ids above T1 read zero
 */
`timescale 1ns/10ps
`include "df_macros.svh"

module df_pixel_buffers (
	input  logic              gclk_DF,
	input  logic              reset_n,
	input  df_pkg::mode_vec_t modes,
	input  df_pkg::buf_id_t   rd_buf,
	input  df_pkg::lane_t     rd_row,
	output df_pkg::pix_word_t rd_word,
	df_step_if.buffers        step
);

	localparam int PIX_W = $bits(df_pkg::pixel_t);

	df_pkg::pix_word_t bufs [df_pkg::BUF0:df_pkg::T1][0:`DF_LANES-1];
	df_pkg::pixel_t    p_col [0:`DF_LANES-1];  // byte written to each row, p side
	df_pkg::pixel_t    q_col [0:`DF_LANES-1];

	// ------------------------------------------------------------------------
	// transposed column data
	// ------------------------------------------------------------------------
	always_comb begin
		for (int r = 0; r < `DF_LANES; r++) begin
			p_col[r] = step.p_word[(`DF_LANES - 1 - r) * PIX_W +: PIX_W];  // rows get p3..p0
			q_col[r] = step.q_word[r * PIX_W +: PIX_W];                    // rows get q0..q3
		end
	end

	// ------------------------------------------------------------------------
	// buffer update
	// ------------------------------------------------------------------------
	always_ff @(posedge gclk_DF or negedge reset_n) begin
		if (!reset_n) begin
			for (int b = df_pkg::BUF0; b <= df_pkg::T1; b++)
				for (int r = 0; r < `DF_LANES; r++)
					bufs[b][r] <= '0;
		end
		else if (step.commit) begin
			for (int b = df_pkg::BUF0; b <= df_pkg::T1; b++) begin
				case (modes[b])
					df_pkg::MODE_ROW_Q:
						bufs[b][step.lane] <= step.q_word;
					df_pkg::MODE_COL_P:
						for (int r = 0; r < `DF_LANES; r++)
							bufs[b][r][step.lane * PIX_W +: PIX_W] <= p_col[r];
					df_pkg::MODE_COL_Q:
						for (int r = 0; r < `DF_LANES; r++)
							bufs[b][r][step.lane * PIX_W +: PIX_W] <= q_col[r];
					default: ;  // hold
				endcase
			end
		end
	end

	// ------------------------------------------------------------------------
	// read-back
	// ------------------------------------------------------------------------
	always_comb begin
		if (rd_buf > df_pkg::T1)
			rd_word = '0;
		else
			rd_word = bufs[rd_buf][rd_row];
	end

endmodule

//--- df_buffer_top.sv
/*
 * deblocking buffer and transpose bank behind a wishbone classic slave
 * writes: 24 stores p, 25 commits a step with q; reads: 0..23 rows, 26 status
 * one step per q write, the edge schedule is generated inside
 */
`timescale 1ns/10ps

module df_buffer_top (
	input  logic              gclk_DF,
	input  logic              reset_n,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  df_pkg::wb_adr_t   wb_adr,
	input  df_pkg::pix_word_t wb_dat_i,
	output df_pkg::pix_word_t wb_dat_o,
	output logic              wb_ack
);

	df_pkg::mode_vec_t modes;
	df_pkg::buf_id_t   rd_buf;
	df_pkg::lane_t     rd_row;
	df_pkg::pix_word_t rd_word;

	df_step_if step_if ();

	df_bus_fsm df_bus_fsm_inst (
		.gclk_DF  (gclk_DF),
		.reset_n  (reset_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack   (wb_ack),
		.rd_word  (rd_word),
		.rd_buf   (rd_buf),
		.rd_row   (rd_row),
		.step     (step_if.bus)
	);

	df_edge_counter df_edge_counter_inst (
		.gclk_DF (gclk_DF),
		.reset_n (reset_n),
		.step    (step_if.counter)
	);

	df_schedule_decoder df_schedule_decoder_inst (
		.step  (step_if.decoder),
		.modes (modes)
	);

	df_pixel_buffers df_pixel_buffers_inst (
		.gclk_DF (gclk_DF),
		.reset_n (reset_n),
		.modes   (modes),
		.rd_buf  (rd_buf),
		.rd_row  (rd_row),
		.rd_word (rd_word),
		.step    (step_if.buffers)
	);

endmodule

//--- df_properties.sv
/*
 * bound checks on the wishbone handshake and the step counter
 * bound to df_buffer_top, reads the commit pulse and lane of step_if
 */
`timescale 1ns/10ps

module df_properties (
	input logic          gclk_DF,
	input logic          reset_n,
	input logic          wb_cyc,
	input logic          wb_stb,
	input logic          wb_ack,
	input logic          commit,
	input df_pkg::lane_t lane
);

	// ack is a single-cycle pulse
	ack_single: assert property (@(posedge gclk_DF) disable iff (!reset_n)
		wb_ack |=> !wb_ack)
		else $error("ack high for two cycles");

	ack_after_req: assert property (@(posedge gclk_DF) disable iff (!reset_n)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else $error("ack without a request in the cycle before");

	commit_in_ack: assert property (@(posedge gclk_DF) disable iff (!reset_n)
		commit |-> wb_ack)
		else $error("commit outside an ack cycle");

	// lane wraps by width
	lane_step: assert property (@(posedge gclk_DF) disable iff (!reset_n)
		commit |=> (lane == df_pkg::lane_t'($past(lane) + 1'b1)))
		else $error("lane did not advance by one after commit");

endmodule

bind df_buffer_top df_properties df_properties_inst (
	.gclk_DF (gclk_DF),
	.reset_n (reset_n),
	.wb_cyc  (wb_cyc),
	.wb_stb  (wb_stb),
	.wb_ack  (wb_ack),
	.commit  (step_if.commit),
	.lane    (step_if.lane)
);

//--- df_tb.sv
/*
 * directed testbench for df_buffer_top, one wishbone master, one access at a time
 * keeps its own schedule table and a model of the 24 buffer words
 * inputs change 1 ns after the rising edge, outputs are sampled there too
 */
`timescale 1ns/10ps
`include "df_macros.svh"

module df_tb;

	localparam int TIMEOUT_CYCLES = 20000;  // about twice the full run
	localparam int NUM_WORDS      = 6 * `DF_LANES;
	localparam int ACK_WAIT       = 4;

	logic              gclk_DF;
	logic              reset_n;
	logic              wb_cyc;
	logic              wb_stb;
	logic              wb_we;
	df_pkg::wb_adr_t   wb_adr;
	df_pkg::pix_word_t wb_dat_i;
	df_pkg::pix_word_t wb_dat_o;
	logic              wb_ack;

	df_pkg::pix_word_t model_buf [0:NUM_WORDS-1];  // indexed by read address
	df_pkg::edge_t     model_edge;
	df_pkg::lane_t     model_lane;
	int                errors;
	int                checks;
	int                cycle_count;

	df_buffer_top df_buffer_top_inst (
		.gclk_DF  (gclk_DF),
		.reset_n  (reset_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack   (wb_ack)
	);

	initial begin
		gclk_DF = 1'b0;
		forever #5 gclk_DF = ~gclk_DF;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge gclk_DF);
			cycle_count++;
		end
		$display("timeout after %0d cycles, the run did not finish", cycle_count);
		$display("CHECKS FAILED");
		$finish;
	end

	// ------------------------------------------------------------------------
	// schedule table, one char per edge: R row q, P column p, Q column q
	// ------------------------------------------------------------------------
	function automatic logic [7:0] sched_char(input int b, input int e);
		string s;
		case (b)
			0:       s = "RP..RPR...P.R.P.RP..R.R...P.R.P.RP..R.P.RP..R.P.";
			1:       s = ".R....P.R.Q..R...R....P.R.Q..R...Q...R...Q...R..";
			2:       s = "..RP...R...P......RP.Q.R...P..Q...RP..Q...RP..Q.";
			3:       s = "...R...P...Q.......R...P.Q.Q.......Q.......Q....";
			4:       s = "....P...P...P..P....P...P...P..P....P..P....P..P";  // t0
			default: s = ".........P...P.......P...P...P.Q.....P.Q.....P.Q";  // t1
		endcase
		return s[e];
	endfunction

	// apply one committed step to the model, then advance edge and lane
	task automatic model_step(input df_pkg::pix_word_t p, input df_pkg::pix_word_t q);
		int         l;
		int         idx;
		logic [7:0] m;
		l = int'(model_lane);
		for (int b = 0; b < 6; b++) begin
			m = sched_char(b, int'(model_edge));
			for (int r = 0; r < `DF_LANES; r++) begin
				idx = b * `DF_LANES + r;
				case (m)
					"R": if (r == l) model_buf[idx] = q;
					"P": model_buf[idx][l*8 +: 8] = p[(3 - r)*8 +: 8];  // row 0 gets p3
					"Q": model_buf[idx][l*8 +: 8] = q[r*8 +: 8];
					default: ;
				endcase
			end
		end
		if (l == `DF_LANES - 1)
			model_edge = (int'(model_edge) == `DF_EDGES - 1) ? '0 : model_edge + 1'b1;
		model_lane = model_lane + 1'b1;
	endtask

	// ------------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------------
	task automatic check_word(input string name, input df_pkg::pix_word_t got,
		input df_pkg::pix_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_edge(input string name, input df_pkg::edge_t got,
		input df_pkg::edge_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_lane(input string name, input df_pkg::lane_t got,
		input df_pkg::lane_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// ------------------------------------------------------------------------
	// bus master
	// ------------------------------------------------------------------------
	task automatic bus_access(input logic we, input int adr, input df_pkg::pix_word_t dat,
		output df_pkg::pix_word_t rdat);
		int waited;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = df_pkg::wb_adr_t'(adr);
		wb_dat_i = dat;
		waited   = 0;
		do begin
			@(posedge gclk_DF);
			#1;
			waited++;
		end while (!wb_ack && waited < ACK_WAIT);
		rdat = wb_dat_o;
		checks++;
		if (!wb_ack) begin
			errors++;
			$display("no ack within %0d cycles for address %0d", ACK_WAIT, adr);
		end
		@(posedge gclk_DF);  // edge ending the ack cycle
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		if (wb_ack) begin
			errors++;
			$display("ack still high one cycle after it was seen, address %0d", adr);
		end
	endtask

	task automatic bus_write(input int adr, input df_pkg::pix_word_t dat);
		df_pkg::pix_word_t unused;
		bus_access(1'b1, adr, dat, unused);
	endtask

	task automatic bus_read(input int adr, output df_pkg::pix_word_t dat);
		bus_access(1'b0, adr, '0, dat);
	endtask

	task automatic do_step(input df_pkg::pix_word_t p, input df_pkg::pix_word_t q);
		bus_write(`DF_ADR_P, p);
		bus_write(`DF_ADR_Q, q);
		model_step(p, q);
	endtask

	task automatic compare_status();
		df_pkg::pix_word_t s;
		bus_read(`DF_ADR_STATUS, s);
		check_edge("status edge", df_pkg::edge_t'(s[7:2]), model_edge);
		check_lane("status lane", df_pkg::lane_t'(s[1:0]), model_lane);
		check_word("status upper bits", s & 32'hffff_ff00, '0);
	endtask

	task automatic compare_buffers();
		df_pkg::pix_word_t d;
		for (int a = 0; a < NUM_WORDS; a++) begin
			bus_read(a, d);
			check_word($sformatf("buffer %0d row %0d", a / 4, a % 4), d, model_buf[a]);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("test %s: %0d errors", name, errors - errors_before);
	endtask

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------
	task automatic test_reset();
		int e0;
		e0 = errors;
		compare_buffers();
		compare_status();
		report_test("reset", e0);
	endtask

	task automatic run_macroblock(input string name);
		int                e0;
		df_pkg::pix_word_t s;
		e0 = errors;
		for (int n = 0; n < `DF_EDGES * `DF_LANES; n++) begin
			do_step(df_pkg::pix_word_t'($urandom()), df_pkg::pix_word_t'($urandom()));
			compare_status();
			if (model_lane == 0)
				compare_buffers();  // after the fourth step of an edge
		end
		bus_read(`DF_ADR_STATUS, s);  // counters back at the first edge
		check_edge("edge after macroblock", df_pkg::edge_t'(s[7:2]), '0);
		check_lane("lane after macroblock", df_pkg::lane_t'(s[1:0]), '0);
		report_test(name, e0);
	endtask

	task automatic test_no_commit();
		int                e0;
		df_pkg::pix_word_t p_last;
		e0 = errors;
		for (int k = 0; k < 5; k++) begin  // fifth step lands on a column-p edge
			bus_write(`DF_ADR_P, df_pkg::pix_word_t'($urandom()));
			p_last = df_pkg::pix_word_t'($urandom());
			bus_write(`DF_ADR_P, p_last);
			bus_write(`DF_ADR_STATUS, df_pkg::pix_word_t'($urandom()));
			bus_write(29, df_pkg::pix_word_t'($urandom()));
			bus_write(5, df_pkg::pix_word_t'($urandom()));
			compare_status();
			compare_buffers();
			do_step(p_last, df_pkg::pix_word_t'($urandom()));
			compare_buffers();
			compare_status();
		end
		report_test("no commit without q", e0);
	endtask

	task automatic test_handshake();
		int                e0;
		int                acks;
		df_pkg::pix_word_t d;
		e0 = errors;
		// stb alone, as a q write
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = df_pkg::wb_adr_t'(`DF_ADR_Q);
		wb_dat_i = df_pkg::pix_word_t'($urandom());
		repeat (6) begin
			@(posedge gclk_DF);
			#1;
			checks++;
			if (wb_ack) begin
				errors++;
				$display("ack given to stb without cyc");
			end
		end
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		compare_status();
		compare_buffers();

		// held status read, one ack every other cycle
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_adr = df_pkg::wb_adr_t'(`DF_ADR_STATUS);
		acks   = 0;
		repeat (6) begin
			@(posedge gclk_DF);
			#1;
			if (wb_ack) begin
				acks++;
				check_word("held read data", wb_dat_o,
					df_pkg::pix_word_t'({model_edge, model_lane}));
			end
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		checks++;
		if (acks != 3) begin
			errors++;
			$display("held read over 6 cycles got %0d acks instead of 3", acks);
		end

		for (int a = 27; a < 32; a++) begin
			bus_read(a, d);
			check_word($sformatf("unmapped read %0d", a), d, '0);
		end
		report_test("handshake", e0);
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		reset_n  = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_i = '0;
		errors   = 0;
		checks   = 0;
		model_edge = '0;
		model_lane = '0;
		for (int a = 0; a < NUM_WORDS; a++)
			model_buf[a] = '0;
		void'($urandom(32'h022f_e164));

		repeat (3) @(posedge gclk_DF);
		#1;
		reset_n = 1'b1;

		test_reset();
		run_macroblock("macroblock 1");
		run_macroblock("macroblock 2");
		test_no_commit();
		test_handshake();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+.
df_pkg.sv
df_step_if.sv
df_bus_fsm.sv
df_edge_counter.sv
df_schedule_decoder.sv
df_pixel_buffers.sv
df_buffer_top.sv
df_properties.sv
df_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the deblocking buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module df_tb -o df_tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/df_tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
echo "pass message not found"
exit 1
